// ==== logic/audio_regs_pkg.sv ====
// Register map, control and status bit positions and timer limits for the CPU side.
package audio_regs_pkg;

	// CPU register addresses.
	typedef enum logic [3:0] {
		REG_RATE      = 4'd0,
		REG_CONTROL   = 4'd1,
		REG_CH0_ADDR  = 4'd2,
		REG_CH0_COUNT = 4'd3,
		REG_CH1_ADDR  = 4'd4,
		REG_CH1_COUNT = 4'd5,
		REG_STATUS    = 4'd6
	} audio_reg_e;

	// Sample period in clocks.
	localparam int RATE_WIDTH = 16;
	localparam logic [RATE_WIDTH-1:0] RATE_RESET = 16'd256;
	// Shortest period that still lets both FIFOs refill between ticks.
	localparam logic [RATE_WIDTH-1:0] RATE_MIN = 16'd16;

	localparam int CONTROL_ENABLE = 0;

	// Status word bits.
	localparam int STATUS_PRIMED0 = 0;
	localparam int STATUS_PRIMED1 = 1;
	localparam int STATUS_BUSY0   = 2;
	localparam int STATUS_BUSY1   = 3;

endpackage

// ==== logic/audio_data_pkg.sv ====
// Sample and word widths, FIFO depth and channel states for the audio data path.
package audio_data_pkg;

	// Signed PCM sample for one side.
	localparam int SAMPLE_WIDTH = 16;

	// Stereo memory word with the left sample in the low half.
	localparam int WORD_WIDTH = 32;

	// Default channel FIFO depth in words.
	localparam int BUFFER_DEPTH = 4;

	// Channel playback FSM.
	typedef enum logic [1:0] {
		IDLE,
		PRIME,
		PLAY
	} channel_state_e;

endpackage

// ==== logic/audio_register_file.sv ====
// Wishbone classic slave with the rate, enable and channel setup registers and start pulses.
module audio_register_file (
	input  logic        i_clock,
	input  logic        i_arst_n,
	input  logic        i_wb_cyc,
	input  logic        i_wb_stb,
	input  logic        i_wb_we,
	input  logic [3:0]  i_wb_adr,
	input  logic [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic        o_wb_ack,
	input  logic [1:0]  i_primed,
	input  logic [1:0]  i_busy,
	output logic [audio_regs_pkg::RATE_WIDTH-1:0] o_rate,
	output logic        o_enable,
	output logic        o_start0,
	output logic [31:0] o_addr0,
	output logic [31:0] o_count0,
	output logic        o_start1,
	output logic [31:0] o_addr1,
	output logic [31:0] o_count1
);
	logic access;
	logic [31:0] read_data;
	logic [audio_regs_pkg::RATE_WIDTH-1:0] wr_rate;
	audio_regs_pkg::audio_reg_e reg_sel;

	// New access when strobed and not already acknowledged.
	assign access = i_wb_cyc && i_wb_stb && !o_wb_ack;
	assign reg_sel = audio_regs_pkg::audio_reg_e'(i_wb_adr);

	// Short periods are raised to the minimum.
	assign wr_rate = (i_wb_dat[audio_regs_pkg::RATE_WIDTH-1:0] < audio_regs_pkg::RATE_MIN) ?
		audio_regs_pkg::RATE_MIN : i_wb_dat[audio_regs_pkg::RATE_WIDTH-1:0];

	always_comb begin
		read_data = '0;
		case (reg_sel)
			audio_regs_pkg::REG_RATE:      read_data[audio_regs_pkg::RATE_WIDTH-1:0] = o_rate;
			audio_regs_pkg::REG_CONTROL:   read_data[audio_regs_pkg::CONTROL_ENABLE] = o_enable;
			audio_regs_pkg::REG_CH0_ADDR:  read_data = o_addr0;
			audio_regs_pkg::REG_CH0_COUNT: read_data = o_count0;
			audio_regs_pkg::REG_CH1_ADDR:  read_data = o_addr1;
			audio_regs_pkg::REG_CH1_COUNT: read_data = o_count1;
			audio_regs_pkg::REG_STATUS: begin
				read_data[audio_regs_pkg::STATUS_PRIMED0] = i_primed[0];
				read_data[audio_regs_pkg::STATUS_PRIMED1] = i_primed[1];
				read_data[audio_regs_pkg::STATUS_BUSY0]   = i_busy[0];
				read_data[audio_regs_pkg::STATUS_BUSY1]   = i_busy[1];
			end
			default:                       read_data = '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wb_ack <= 1'b0;
			o_rate   <= audio_regs_pkg::RATE_RESET;
			o_enable <= 1'b0;
			o_start0 <= 1'b0;
			o_start1 <= 1'b0;
			o_addr0  <= '0;
			o_count0 <= '0;
			o_addr1  <= '0;
			o_count1 <= '0;
		end else begin
			o_wb_ack <= access;
			o_start0 <= 1'b0;
			o_start1 <= 1'b0;
			if (access && i_wb_we) begin
				case (reg_sel)
					audio_regs_pkg::REG_RATE:     o_rate <= wr_rate;
					audio_regs_pkg::REG_CONTROL:  o_enable <= i_wb_dat[audio_regs_pkg::CONTROL_ENABLE];
					audio_regs_pkg::REG_CH0_ADDR: o_addr0 <= i_wb_dat;
					audio_regs_pkg::REG_CH0_COUNT: begin
						o_count0 <= i_wb_dat;
						o_start0 <= 1'b1;
					end
					audio_regs_pkg::REG_CH1_ADDR: o_addr1 <= i_wb_dat;
					audio_regs_pkg::REG_CH1_COUNT: begin
						o_count1 <= i_wb_dat;
						o_start1 <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// Read data is captured with the ack.
	always_ff @(posedge i_clock) begin
		if (access) begin
			o_wb_dat <= read_data;
		end
	end

	ack_follows_strobe: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		o_wb_ack |-> $past(i_wb_cyc && i_wb_stb));

endmodule

// ==== logic/audio_sample_timer.sv ====
// Sample rate timer that pulses a one-cycle tick every programmed period while enabled.
module audio_sample_timer (
	input  logic i_clock,
	input  logic i_arst_n,
	input  logic [audio_regs_pkg::RATE_WIDTH-1:0] i_rate,
	input  logic i_enable,
	output logic o_tick
);
	logic [audio_regs_pkg::RATE_WIDTH-1:0] count;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			count  <= '0;
			o_tick <= 1'b0;
		end else if (!i_enable) begin
			// Preloaded so the first tick lands one full period after enable.
			count  <= i_rate - 1'b1;
			o_tick <= 1'b0;
		end else if (count == '0) begin
			count  <= i_rate - 1'b1;
			o_tick <= 1'b1;
		end else begin
			count  <= count - 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

// ==== logic/audio_channel.sv ====
// One DMA playback channel that prefetches stereo words into a FIFO and plays one per tick.
module audio_channel #(
	parameter int BUFFER_DEPTH = audio_data_pkg::BUFFER_DEPTH
) (
	input  logic i_clock,
	input  logic i_arst_n,
	input  logic i_start,
	input  logic [audio_data_pkg::WORD_WIDTH-1:0] i_addr,
	input  logic [audio_data_pkg::WORD_WIDTH-1:0] i_count,
	output logic o_fetch_req,
	output logic [audio_data_pkg::WORD_WIDTH-1:0] o_fetch_adr,
	input  logic i_fetch_ack,
	input  logic [audio_data_pkg::WORD_WIDTH-1:0] i_fetch_dat,
	input  logic i_tick,
	output logic [audio_data_pkg::SAMPLE_WIDTH-1:0] o_sample_left,
	output logic [audio_data_pkg::SAMPLE_WIDTH-1:0] o_sample_right,
	output logic o_primed,
	output logic o_busy
);
	localparam int PTR_WIDTH = $clog2(BUFFER_DEPTH);
	localparam int FILL_WIDTH = $clog2(BUFFER_DEPTH + 1);
	localparam logic [FILL_WIDTH-1:0] FULL = FILL_WIDTH'(BUFFER_DEPTH);

	audio_data_pkg::channel_state_e state;
	logic [audio_data_pkg::WORD_WIDTH-1:0] mem [BUFFER_DEPTH];
	logic [audio_data_pkg::WORD_WIDTH-1:0] next_adr;
	logic [audio_data_pkg::WORD_WIDTH-1:0] remaining;
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [FILL_WIDTH-1:0] fill;
	logic discard;
	logic push;
	logic pop;
	logic raise;
	logic fetched_all;

	// A fetch still in flight at restart belongs to the old program.
	assign push = i_fetch_ack && !discard && !i_start;
	assign pop = i_tick && state == audio_data_pkg::PLAY && fill != '0 && !i_start;
	assign raise = state != audio_data_pkg::IDLE && !o_fetch_req && remaining != '0 &&
		fill != FULL && !i_start;
	assign fetched_all = remaining == '0 && !o_fetch_req;
	assign o_busy = state != audio_data_pkg::IDLE;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state          <= audio_data_pkg::IDLE;
			o_fetch_req    <= 1'b0;
			discard        <= 1'b0;
			remaining      <= '0;
			next_adr       <= '0;
			wr_ptr         <= '0;
			rd_ptr         <= '0;
			fill           <= '0;
			o_primed       <= 1'b0;
			o_sample_left  <= '0;
			o_sample_right <= '0;
		end else begin
			if (i_fetch_ack) begin
				o_fetch_req <= 1'b0;
			end else if (raise) begin
				o_fetch_req <= 1'b1;
			end
			if (raise) begin
				next_adr  <= next_adr + 32'd4;
				remaining <= remaining - 1'b1;
			end
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				fill <= fill + 1'b1;
			end else if (pop && !push) begin
				fill <= fill - 1'b1;
			end
			if (pop) begin
				{o_sample_right, o_sample_left} <= mem[rd_ptr];
			end else if (i_tick) begin
				o_sample_left  <= '0;
				o_sample_right <= '0;
			end

			if (i_start) begin
				// Flush and reload, overriding the updates above.
				discard   <= o_fetch_req && !i_fetch_ack;
				next_adr  <= i_addr;
				remaining <= i_count;
				wr_ptr    <= '0;
				rd_ptr    <= '0;
				fill      <= '0;
				o_primed  <= 1'b0;
				state     <= audio_data_pkg::PRIME;
			end else begin
				if (i_fetch_ack) begin
					discard <= 1'b0;
				end
				case (state)
					audio_data_pkg::PRIME: begin
						if (fill == FULL || fetched_all) begin
							o_primed <= 1'b1;
							state    <= audio_data_pkg::PLAY;
						end
					end
					audio_data_pkg::PLAY: begin
						if (fetched_all && fill == '0) begin
							state <= audio_data_pkg::IDLE;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// Fetch address and FIFO storage.
	always_ff @(posedge i_clock) begin
		if (raise) begin
			o_fetch_adr <= next_adr;
		end
		if (push) begin
			mem[wr_ptr] <= i_fetch_dat;
		end
	end

	no_push_when_full: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		push |-> fill != FULL);

	fetch_held_until_ack: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		o_fetch_req && !i_fetch_ack |=> o_fetch_req && $stable(o_fetch_adr));

endmodule

// ==== logic/audio_dma_arbiter.sv ====
// Round-robin Wishbone classic DMA master serving single-word fetches for two channels.
module audio_dma_arbiter (
	input  logic i_clock,
	input  logic i_arst_n,
	input  logic i_req0,
	input  logic [audio_data_pkg::WORD_WIDTH-1:0] i_adr0,
	output logic o_ack0,
	input  logic i_req1,
	input  logic [audio_data_pkg::WORD_WIDTH-1:0] i_adr1,
	output logic o_ack1,
	output logic [audio_data_pkg::WORD_WIDTH-1:0] o_fetch_dat,
	output logic o_dma_cyc,
	output logic o_dma_stb,
	output logic [audio_data_pkg::WORD_WIDTH-1:0] o_dma_adr,
	input  logic [audio_data_pkg::WORD_WIDTH-1:0] i_dma_dat,
	input  logic i_dma_ack
);
	logic active;
	logic grant;
	logic pick;
	logic launch;

	// Favor the channel not served last when both ask.
	assign pick = (i_req0 && i_req1) ? !grant : i_req1;
	// Never starts in the cycle after ack, which gives the idle gap.
	assign launch = !active && (i_req0 || i_req1);

	assign o_dma_cyc = active;
	assign o_dma_stb = active;
	assign o_ack0 = active && i_dma_ack && !grant;
	assign o_ack1 = active && i_dma_ack && grant;
	assign o_fetch_dat = i_dma_dat;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			active <= 1'b0;
			// Channel 0 wins the first tie.
			grant  <= 1'b1;
		end else if (launch) begin
			active <= 1'b1;
			grant  <= pick;
		end else if (active && i_dma_ack) begin
			active <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (launch) begin
			o_dma_adr <= pick ? i_adr1 : i_adr0;
		end
	end

	one_ack_at_a_time: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		!(o_ack0 && o_ack1));

endmodule

// ==== logic/audio_mixer.sv ====
// Stereo mixer that adds two channels with signed saturation and strobes each result.
module audio_mixer (
	input  logic i_clock,
	input  logic i_arst_n,
	input  logic i_tick,
	input  logic [audio_data_pkg::SAMPLE_WIDTH-1:0] i_left0,
	input  logic [audio_data_pkg::SAMPLE_WIDTH-1:0] i_right0,
	input  logic [audio_data_pkg::SAMPLE_WIDTH-1:0] i_left1,
	input  logic [audio_data_pkg::SAMPLE_WIDTH-1:0] i_right1,
	output logic [audio_data_pkg::SAMPLE_WIDTH-1:0] o_sample_left,
	output logic [audio_data_pkg::SAMPLE_WIDTH-1:0] o_sample_right,
	output logic o_sample_strobe
);
	logic tick_d;

	// Signed add, clipped to the sample range on overflow.
	function automatic logic [audio_data_pkg::SAMPLE_WIDTH-1:0] sat_add(
		input logic [audio_data_pkg::SAMPLE_WIDTH-1:0] a,
		input logic [audio_data_pkg::SAMPLE_WIDTH-1:0] b
	);
		logic [audio_data_pkg::SAMPLE_WIDTH:0] sum;
		sum = {a[audio_data_pkg::SAMPLE_WIDTH-1], a} + {b[audio_data_pkg::SAMPLE_WIDTH-1], b};
		if (sum[audio_data_pkg::SAMPLE_WIDTH] == sum[audio_data_pkg::SAMPLE_WIDTH-1]) begin
			return sum[audio_data_pkg::SAMPLE_WIDTH-1:0];
		end
		return sum[audio_data_pkg::SAMPLE_WIDTH] ? 16'h8000 : 16'h7fff;
	endfunction

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			tick_d          <= 1'b0;
			o_sample_strobe <= 1'b0;
			o_sample_left   <= '0;
			o_sample_right  <= '0;
		end else begin
			tick_d          <= i_tick;
			o_sample_strobe <= tick_d;
			// Channel samples settle one cycle after the tick.
			if (tick_d) begin
				o_sample_left  <= sat_add(i_left0, i_left1);
				o_sample_right <= sat_add(i_right0, i_right1);
			end
		end
	end

endmodule

// ==== logic/audio_controller.sv ====
// Top level of the two-channel audio playback controller with CPU and DMA Wishbone ports.
module audio_controller (
	input  logic        i_clock,
	input  logic        i_arst_n,
	input  logic        i_wb_cyc,
	input  logic        i_wb_stb,
	input  logic        i_wb_we,
	input  logic [3:0]  i_wb_adr,
	input  logic [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic        o_wb_ack,
	output logic        o_dma_cyc,
	output logic        o_dma_stb,
	output logic [audio_data_pkg::WORD_WIDTH-1:0] o_dma_adr,
	input  logic [audio_data_pkg::WORD_WIDTH-1:0] i_dma_dat,
	input  logic        i_dma_ack,
	output logic [audio_data_pkg::SAMPLE_WIDTH-1:0] o_sample_left,
	output logic [audio_data_pkg::SAMPLE_WIDTH-1:0] o_sample_right,
	output logic        o_sample_strobe
);
	logic [audio_regs_pkg::RATE_WIDTH-1:0] rate;
	logic enable;
	logic tick;
	logic [audio_data_pkg::WORD_WIDTH-1:0] fetch_dat;
	logic start [2];
	logic [audio_data_pkg::WORD_WIDTH-1:0] addr [2];
	logic [audio_data_pkg::WORD_WIDTH-1:0] count [2];
	logic req [2];
	logic ack [2];
	logic [audio_data_pkg::WORD_WIDTH-1:0] fetch_adr [2];
	logic [audio_data_pkg::SAMPLE_WIDTH-1:0] left [2];
	logic [audio_data_pkg::SAMPLE_WIDTH-1:0] right [2];
	logic [1:0] primed;
	logic [1:0] busy;

	audio_register_file regs_i (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
		.i_primed(primed), .i_busy(busy), .o_rate(rate), .o_enable(enable),
		.o_start0(start[0]), .o_addr0(addr[0]), .o_count0(count[0]),
		.o_start1(start[1]), .o_addr1(addr[1]), .o_count1(count[1])
	);

	audio_sample_timer timer_i (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_rate(rate), .i_enable(enable), .o_tick(tick)
	);

	for (genvar ch = 0; ch < 2; ch++) begin : g_channel
		audio_channel #(
			.BUFFER_DEPTH(audio_data_pkg::BUFFER_DEPTH)
		) channel_i (
			.i_clock(i_clock), .i_arst_n(i_arst_n),
			.i_start(start[ch]), .i_addr(addr[ch]), .i_count(count[ch]),
			.o_fetch_req(req[ch]), .o_fetch_adr(fetch_adr[ch]),
			.i_fetch_ack(ack[ch]), .i_fetch_dat(fetch_dat), .i_tick(tick),
			.o_sample_left(left[ch]), .o_sample_right(right[ch]),
			.o_primed(primed[ch]), .o_busy(busy[ch])
		);
	end

	audio_dma_arbiter arbiter_i (
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_req0(req[0]), .i_adr0(fetch_adr[0]), .o_ack0(ack[0]),
		.i_req1(req[1]), .i_adr1(fetch_adr[1]), .o_ack1(ack[1]),
		.o_fetch_dat(fetch_dat),
		.o_dma_cyc(o_dma_cyc), .o_dma_stb(o_dma_stb), .o_dma_adr(o_dma_adr),
		.i_dma_dat(i_dma_dat), .i_dma_ack(i_dma_ack)
	);

	audio_mixer mixer_i (
		.i_clock(i_clock), .i_arst_n(i_arst_n), .i_tick(tick),
		.i_left0(left[0]), .i_right0(right[0]), .i_left1(left[1]), .i_right1(right[1]),
		.o_sample_left(o_sample_left), .o_sample_right(o_sample_right),
		.o_sample_strobe(o_sample_strobe)
	);

endmodule

// ==== tb/audio_memory_model.sv ====
// Testbench memory on the DMA bus that stalls at random and returns each byte address as data.
module audio_memory_model (
	input  logic        i_clock,
	input  logic        i_arst_n,
	input  logic        i_cyc,
	input  logic        i_stb,
	input  logic [31:0] i_adr,
	output logic [31:0] o_dat,
	output logic        o_ack
);
	int seed;
	logic pending;
	logic [1:0] stall;

	initial begin
		seed = 32'h0ebb_2afa;
	end

	always @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ack   <= 1'b0;
			o_dat   <= '0;
			pending <= 1'b0;
			stall   <= '0;
		end else begin
			o_ack <= 1'b0;
			if (i_cyc && i_stb && !o_ack) begin
				if (!pending) begin
					// Draw 0 to 3 wait states for this access.
					pending <= 1'b1;
					stall   <= 2'($random(seed));
				end else if (stall != '0) begin
					stall <= stall - 1'b1;
				end else begin
					// Word content is its own byte address.
					o_ack   <= 1'b1;
					o_dat   <= i_adr;
					pending <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== tb/audio_tb.sv ====
// Testbench for the audio controller; runs the cases of the patterns file and checks every sample.
module audio_tb;
	localparam int MAX_CASES = 16;
	localparam int COLUMNS = 6;
	localparam int ACK_TIMEOUT = 16;
	localparam int POLL_LIMIT = 200;

	logic clock;
	logic arst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [3:0] wb_adr;
	logic [31:0] wb_wdat;
	logic [31:0] wb_rdat;
	logic wb_ack;
	logic dma_cyc;
	logic dma_stb;
	logic [31:0] dma_adr;
	logic [31:0] dma_dat;
	logic dma_ack;
	logic [15:0] sample_left;
	logic [15:0] sample_right;
	logic sample_strobe;

	logic [31:0] patterns [MAX_CASES*COLUMNS];
	logic [31:0] base0;
	logic [31:0] base1;
	logic [31:0] count0;
	logic [31:0] count1;
	logic [31:0] exp_adr0;
	logic [31:0] exp_adr1;
	logic [31:0] held_adr;
	logic held;
	int fetches0;
	int fetches1;
	int idx0;
	int idx1;
	int tick_period;

	audio_controller dut_i (
		.i_clock(clock), .i_arst_n(arst_n),
		.i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
		.i_wb_adr(wb_adr), .i_wb_dat(wb_wdat), .o_wb_dat(wb_rdat), .o_wb_ack(wb_ack),
		.o_dma_cyc(dma_cyc), .o_dma_stb(dma_stb), .o_dma_adr(dma_adr),
		.i_dma_dat(dma_dat), .i_dma_ack(dma_ack),
		.o_sample_left(sample_left), .o_sample_right(sample_right),
		.o_sample_strobe(sample_strobe)
	);

	audio_memory_model memory_i (
		.i_clock(clock), .i_arst_n(arst_n), .i_cyc(dma_cyc), .i_stb(dma_stb),
		.i_adr(dma_adr), .o_dat(dma_dat), .o_ack(dma_ack)
	);

	always #2 clock = ~clock;

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout at time %0t: %s", $time, what);
		$display("TEST FAILED");
		$fatal(1, "wait timed out");
	endtask

	// Word k of a channel, or silence once its count is used up.
	function automatic logic [31:0] channel_word(input logic [31:0] base, input logic [31:0] count,
		input int idx);
		if (idx < count) begin
			return base + 32'(4 * idx);
		end
		return '0;
	endfunction

	function automatic logic [15:0] clip_sum(input logic [15:0] a, input logic [15:0] b);
		int total;
		total = int'($signed(a)) + int'($signed(b));
		if (total > 32767) begin
			return 16'h7fff;
		end
		if (total < -32768) begin
			return 16'h8000;
		end
		return 16'(total);
	endfunction

	task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(negedge clock);
		wb_cyc  = 1'b1;
		wb_stb  = 1'b1;
		wb_we   = we;
		wb_adr  = adr;
		wb_wdat = wdat;
		@(negedge clock);
		while (!wb_ack) begin
			if (waited == ACK_TIMEOUT) begin
				stop_on_timeout("CPU bus access was never acknowledged");
			end
			waited++;
			@(negedge clock);
		end
		rdat   = wb_rdat;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_write(input logic [3:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_access(1'b1, adr, wdat, unused);
	endtask

	task automatic bus_read(input logic [3:0] adr, output logic [31:0] rdat);
		bus_access(1'b0, adr, '0, rdat);
	endtask

	// Polls the status word until the masked bits equal the wanted value.
	task automatic wait_status(input logic [3:0] mask, input logic [3:0] wanted, input string what);
		logic [31:0] status;
		int polls;
		polls = 0;
		bus_read(audio_regs_pkg::REG_STATUS, status);
		while ((status[3:0] & mask) != wanted) begin
			if (polls == POLL_LIMIT) begin
				stop_on_timeout(what);
			end
			polls++;
			bus_read(audio_regs_pkg::REG_STATUS, status);
		end
	endtask

	task automatic wait_dma_idle();
		int quiet;
		int waited;
		quiet = 0;
		waited = 0;
		while (quiet < 8) begin
			@(negedge clock);
			quiet = dma_cyc ? 0 : quiet + 1;
			waited++;
			if (waited > POLL_LIMIT) begin
				stop_on_timeout("DMA bus did not go idle after playback was disabled");
			end
		end
	endtask

	task automatic check_next_sample();
		logic [31:0] word0;
		logic [31:0] word1;
		int waited;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
			if (waited > 4 * tick_period + 64) begin
				stop_on_timeout("no sample strobe arrived within the sample period");
			end
		end while (!sample_strobe);
		word0 = channel_word(base0, count0, idx0);
		word1 = channel_word(base1, count1, idx1);
		check_value($sformatf("left sample %0d", idx1), {16'd0, sample_left},
			{16'd0, clip_sum(word0[15:0], word1[15:0])});
		check_value($sformatf("right sample %0d", idx1), {16'd0, sample_right},
			{16'd0, clip_sum(word0[31:16], word1[31:16])});
		idx0++;
		idx1++;
	endtask

	task automatic run_case(input int row);
		logic [31:0] rate;
		logic [31:0] restart_adr;
		logic [31:0] value;
		rate        = patterns[row*COLUMNS];
		base0       = patterns[row*COLUMNS+1];
		count0      = patterns[row*COLUMNS+2];
		base1       = patterns[row*COLUMNS+3];
		count1      = patterns[row*COLUMNS+4];
		restart_adr = patterns[row*COLUMNS+5];
		bus_write(audio_regs_pkg::REG_CONTROL, 32'd0);
		bus_write(audio_regs_pkg::REG_RATE, rate);
		bus_read(audio_regs_pkg::REG_RATE, value);
		check_value("rate readback", value, (rate < 32'd16) ? 32'd16 : rate);
		tick_period = int'(value);
		exp_adr0 = base0;
		exp_adr1 = base1;
		fetches0 = 0;
		fetches1 = 0;
		idx0 = 0;
		idx1 = 0;
		bus_write(audio_regs_pkg::REG_CH0_ADDR, base0);
		bus_write(audio_regs_pkg::REG_CH1_ADDR, base1);
		bus_write(audio_regs_pkg::REG_CH0_COUNT, count0);
		bus_write(audio_regs_pkg::REG_CH1_COUNT, count1);
		wait_status(4'b0011, 4'b0011, "channels never reported primed");
		bus_write(audio_regs_pkg::REG_CONTROL, 32'd1);
		if (restart_adr != '0) begin
			check_next_sample();
			check_next_sample();
			// Pause, let the FIFOs settle, then restart channel 0 elsewhere.
			bus_write(audio_regs_pkg::REG_CONTROL, 32'd0);
			wait_dma_idle();
			base0 = restart_adr;
			exp_adr0 = restart_adr;
			fetches0 = 0;
			idx0 = 0;
			bus_write(audio_regs_pkg::REG_CH0_ADDR, restart_adr);
			bus_write(audio_regs_pkg::REG_CH0_COUNT, count0);
			wait_status(4'b0011, 4'b0011, "restarted channel never reported primed");
			bus_write(audio_regs_pkg::REG_CONTROL, 32'd1);
		end
		while (idx0 <= count0 || idx1 <= count1) begin
			check_next_sample();
		end
		wait_status(4'b1100, 4'b0000, "busy bits did not clear after the last word");
		check_value("channel 0 fetch count", fetches0, count0);
		check_value("channel 1 fetch count", fetches1, count1);
		bus_write(audio_regs_pkg::REG_CONTROL, 32'd0);
	endtask

	// Watches the DMA bus for held strobes and for each channel's address order.
	always @(negedge clock) begin
		if (!arst_n) begin
			held = 1'b0;
		end else begin
			if (held) begin
				check_value("DMA cyc and stb held until ack", {30'd0, dma_cyc, dma_stb}, 32'd3);
				check_value("DMA address held until ack", dma_adr, held_adr);
			end
			if (dma_cyc && dma_stb && dma_ack) begin
				if (dma_adr == exp_adr1) begin
					exp_adr1 = exp_adr1 + 32'd4;
					fetches1++;
				end else begin
					check_value("DMA fetch address", dma_adr, exp_adr0);
					exp_adr0 = exp_adr0 + 32'd4;
					fetches0++;
				end
			end
			held = dma_cyc && dma_stb && !dma_ack;
			held_adr = dma_adr;
		end
	end

	initial begin
		logic [31:0] value;
		int row;
		clock = 1'b0;
		arst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdat = '0;
		exp_adr0 = '0;
		exp_adr1 = '0;
		fetches0 = 0;
		fetches1 = 0;
		tick_period = 256;
		// Unused rows stay zero, and a zero rate ends the case list.
		for (int i = 0; i < MAX_CASES * COLUMNS; i++) begin
			patterns[i] = '0;
		end
		$readmemh("tb/audio_patterns.hex", patterns);
		repeat (10) @(negedge clock);
		arst_n = 1'b1;

		check_value("DMA cyc after reset", {31'd0, dma_cyc}, 32'd0);
		check_value("DMA stb after reset", {31'd0, dma_stb}, 32'd0);
		check_value("CPU ack after reset", {31'd0, wb_ack}, 32'd0);
		check_value("sample strobe after reset", {31'd0, sample_strobe}, 32'd0);
		check_value("left sample after reset", {16'd0, sample_left}, 32'd0);
		check_value("right sample after reset", {16'd0, sample_right}, 32'd0);
		bus_read(audio_regs_pkg::REG_RATE, value);
		check_value("rate after reset", value, 32'd256);
		bus_write(audio_regs_pkg::REG_RATE, 32'd100);
		bus_read(audio_regs_pkg::REG_RATE, value);
		check_value("rate readback", value, 32'd100);
		bus_write(audio_regs_pkg::REG_RATE, 32'd5);
		bus_read(audio_regs_pkg::REG_RATE, value);
		check_value("clamped rate readback", value, 32'd16);
		bus_write(4'd9, 32'hffff_ffff);
		bus_read(4'd9, value);
		check_value("unmapped register 9", value, 32'd0);
		bus_read(4'd15, value);
		check_value("unmapped register 15", value, 32'd0);

		row = 0;
		while (row < MAX_CASES && patterns[row*COLUMNS] != '0) begin
			run_case(row);
			row++;
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== tb/audio_patterns.hex ====
// Columns: rate, channel 0 address, channel 0 count, channel 1 address, channel 1 count,
// channel 0 restart address (0 means no restart). All values hex, address ranges disjoint.
// Channel 0 alone.
0020 00001000 00000006 00000000 00000000 00000000
// Two channels without overflow.
0018 00100020 00000005 20000040 00000007 00000000
// Positive saturation on both sides.
0010 7FF07FF0 00000004 10001000 00000006 00000000
// Negative saturation, rate below the minimum.
0008 80108010 00000006 F000F000 00000003 00000000
// Channel 0 alone, restarted mid-playback.
0030 00300000 00000008 00000000 00000000 00500000
// Restart of channel 0 while channel 1 keeps playing.
0014 12340000 00000003 55550000 00000009 01000000

// ==== files.f ====
logic/audio_regs_pkg.sv
logic/audio_data_pkg.sv
logic/audio_register_file.sv
logic/audio_sample_timer.sv
logic/audio_channel.sv
logic/audio_dma_arbiter.sv
logic/audio_mixer.sv
logic/audio_controller.sv
tb/audio_memory_model.sv
tb/audio_tb.sv

// ==== Makefile ====
# Verilator flow for the audio controller testbench.

VERILATOR ?= verilator
TOP ?= audio_tb
FILE_LIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	-$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
